/* hw/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      wmask_t;
    typedef logic [2:0]      sub_op_t;

    // target functional unit
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BJP    = 2'd1,
        UNIT_MEM    = 2'd2,
        UNIT_MULDIV = 2'd3
    } unit_t;

    // sub_op meaning when the unit is MEM
    typedef enum logic [2:0] {
        MEM_LB  = 3'd0,
        MEM_LH  = 3'd1,
        MEM_LW  = 3'd2,
        MEM_LBU = 3'd3,
        MEM_LHU = 3'd4,
        MEM_SB  = 3'd5,
        MEM_SH  = 3'd6,
        MEM_SW  = 3'd7
    } mem_op_t;

    // branch and jump sub-ops
    parameter sub_op_t BJP_BEQ  = 3'd0;
    parameter sub_op_t BJP_BNE  = 3'd1;
    parameter sub_op_t BJP_JAL  = 3'd2;
    parameter sub_op_t BJP_JALR = 3'd3;
    parameter sub_op_t BJP_BLT  = 3'd4;
    parameter sub_op_t BJP_BGE  = 3'd5;
    parameter sub_op_t BJP_BLTU = 3'd6;
    parameter sub_op_t BJP_BGEU = 3'd7;

    // multiply / divide sub-ops, funct3 order
    parameter sub_op_t MD_MUL    = 3'd0;
    parameter sub_op_t MD_MULH   = 3'd1;
    parameter sub_op_t MD_MULHSU = 3'd2;
    parameter sub_op_t MD_MULHU  = 3'd3;
    parameter sub_op_t MD_DIV    = 3'd4;
    parameter sub_op_t MD_DIVU   = 3'd5;
    parameter sub_op_t MD_REM    = 3'd6;
    parameter sub_op_t MD_REMU   = 3'd7;

endpackage

`default_nettype wire

/* hw/issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface issue_if import dispatch_pkg::*; #(
    parameter int COMMIT_DEPTH = 4
) ();

    localparam int ID_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1;

    logic            valid;
    logic            ready;
    unit_t           unit;
    sub_op_t         sub_op;
    xlen_t           op1;
    xlen_t           op2;
    xlen_t           addr;
    wmask_t          wmask;
    xlen_t           wdata;
    logic            misaligned;
    reg_addr_t       rd_addr;
    logic            rd_we;
    logic [ID_W-1:0] commit_id;

    // operand logic side
    modport producer (
        output valid, unit, sub_op, op1, op2, addr, wmask, wdata, misaligned,
        output rd_addr, rd_we, commit_id,
        input  ready
    );

    // output register side
    modport consumer (
        input  valid, unit, sub_op, op1, op2, addr, wmask, wdata, misaligned,
        input  rd_addr, rd_we, commit_id,
        output ready
    );

endinterface

`default_nettype wire

/* hw/dispatch_hdu.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_hdu import dispatch_pkg::*; #(
    parameter int COMMIT_DEPTH = 4,
    localparam int ID_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1
) (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            inst_valid_i,
    input  wire unit_t           unit_i,
    input  wire sub_op_t         sub_op_i,
    input  wire reg_addr_t       rs1_addr_i,
    input  wire reg_addr_t       rs2_addr_i,
    input  wire reg_addr_t       rd_addr_i,
    input  wire logic            rd_we_i,
    input  wire logic            pipe_ready_i,
    input  wire logic            commit_valid_i,
    input  wire logic [ID_W-1:0] commit_id_i,
    output logic                 inst_ready_o,
    output logic                 accept_o,
    output logic [ID_W-1:0]      alloc_id_o
);

    logic [COMMIT_DEPTH-1:0] pend_q;
    reg_addr_t               rd_q [COMMIT_DEPTH];
    logic                    is_long;
    logic                    is_load;
    logic                    full;
    logic                    reg_hit;
    logic                    hazard;
    logic                    alloc_en;

    // loads only count when they write back
    assign is_load = (unit_i == UNIT_MEM) && (sub_op_i <= sub_op_t'(MEM_LHU));
    assign is_long = (unit_i == UNIT_MULDIV) || (is_load && rd_we_i);
    assign full    = &pend_q;

    always_comb begin
        reg_hit = 1'b0;
        for (int i = 0; i < COMMIT_DEPTH; i++) begin
            if (pend_q[i] && (rd_q[i] != '0)) begin
                if ((rd_q[i] == rs1_addr_i) || (rd_q[i] == rs2_addr_i) ||
                    (rd_we_i && (rd_q[i] == rd_addr_i))) begin
                    reg_hit = 1'b1;
                end
            end
        end
    end

    // lowest free entry wins, so scan from the top down
    always_comb begin
        alloc_id_o = '0;
        for (int i = COMMIT_DEPTH - 1; i >= 0; i--) begin
            if (!pend_q[i]) begin
                alloc_id_o = ID_W'(i);
            end
        end
    end

    assign hazard       = reg_hit || (is_long && full);
    assign inst_ready_o = !hazard && pipe_ready_i;
    assign accept_o     = inst_valid_i && inst_ready_o;
    assign alloc_en     = accept_o && is_long;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= '0;
        end else begin
            if (commit_valid_i) begin
                pend_q[commit_id_i] <= 1'b0;
            end
            if (alloc_en) begin
                pend_q[alloc_id_o] <= 1'b1;
            end
        end
    end

    // no-writeback long ops park x0, which never matches
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rd_q[alloc_id_o] <= rd_we_i ? rd_addr_i : '0;
        end
    end

    // the entry handed out must be a free one
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (reset_i)
        alloc_en |-> !pend_q[alloc_id_o]
    );

    // writeback must only retire IDs handed out earlier
    a_commit_pending: assert property (
        @(posedge clk) disable iff (reset_i)
        commit_valid_i |-> pend_q[commit_id_i]
    );

endmodule

`default_nettype wire

/* hw/dispatch_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_logic import dispatch_pkg::*; #(
    parameter int COMMIT_DEPTH = 4,
    localparam int ID_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1
) (
    input  wire logic            accept_i,
    input  wire logic [ID_W-1:0] alloc_id_i,
    input  wire unit_t           unit_i,
    input  wire sub_op_t         sub_op_i,
    input  wire logic            use_imm_i,
    input  wire xlen_t           rs1_rdata_i,
    input  wire xlen_t           rs2_rdata_i,
    input  wire xlen_t           imm_i,
    input  wire xlen_t           pc_i,
    input  wire reg_addr_t       rd_addr_i,
    input  wire logic            rd_we_i,
    issue_if.producer            issue
);

    mem_op_t mem_op;
    xlen_t   base;
    xlen_t   addr;
    logic    misaligned;
    wmask_t  wmask;
    xlen_t   wdata;

    assign mem_op = mem_op_t'(sub_op_i);

    // one adder for branch targets and memory addresses
    assign base = ((unit_i == UNIT_BJP) && (sub_op_i != BJP_JALR)) ? pc_i : rs1_rdata_i;
    assign addr = base + imm_i;

    always_comb begin
        misaligned = 1'b0;
        if (unit_i == UNIT_MEM) begin
            case (mem_op)
                MEM_LH, MEM_LHU, MEM_SH: misaligned = addr[0];
                MEM_LW, MEM_SW:          misaligned = |addr[1:0];
                default:                 misaligned = 1'b0;
            endcase
        end
    end

    // byte enables follow the low address bits
    always_comb begin
        wmask = '0;
        wdata = '0;
        if (unit_i == UNIT_MEM) begin
            case (mem_op)
                MEM_SB: begin
                    wmask = wmask_t'(4'b0001 << addr[1:0]);
                    wdata = {4{rs2_rdata_i[7:0]}};
                end
                MEM_SH: begin
                    wmask = addr[1] ? 4'b1100 : 4'b0011;
                    wdata = {2{rs2_rdata_i[15:0]}};
                end
                MEM_SW: begin
                    wmask = 4'b1111;
                    wdata = rs2_rdata_i;
                end
                default: begin
                    wmask = '0;
                    wdata = '0;
                end
            endcase
        end
        if (misaligned) begin
            wmask = '0;
        end
    end

    assign issue.valid      = accept_i;
    assign issue.unit       = unit_i;
    assign issue.sub_op     = sub_op_i;
    assign issue.op1        = rs1_rdata_i;
    assign issue.op2        = ((unit_i == UNIT_ALU) && use_imm_i) ? imm_i : rs2_rdata_i;
    assign issue.addr       = addr;
    assign issue.wmask      = wmask;
    assign issue.wdata      = wdata;
    assign issue.misaligned = misaligned;
    assign issue.rd_addr    = rd_addr_i;
    assign issue.rd_we      = rd_we_i;
    assign issue.commit_id  = alloc_id_i;

endmodule

`default_nettype wire

/* hw/dispatch_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_pipe import dispatch_pkg::*; #(
    parameter int COMMIT_DEPTH = 4,
    localparam int ID_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       out_ready_i,
    issue_if.consumer       issue,
    output logic            out_valid_o,
    output unit_t           out_unit_o,
    output sub_op_t         out_sub_op_o,
    output xlen_t           op1_o,
    output xlen_t           op2_o,
    output xlen_t           addr_o,
    output wmask_t          wmask_o,
    output xlen_t           wdata_o,
    output logic            misaligned_o,
    output reg_addr_t       rd_addr_o,
    output logic            rd_we_o,
    output logic [ID_W-1:0] commit_id_o
);

    logic out_valid_q;

    // room when empty or draining this cycle
    assign issue.ready = !out_valid_q || out_ready_i;
    assign out_valid_o = out_valid_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (issue.valid) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            out_unit_o   <= issue.unit;
            out_sub_op_o <= issue.sub_op;
            op1_o        <= issue.op1;
            op2_o        <= issue.op2;
            addr_o       <= issue.addr;
            wmask_o      <= issue.wmask;
            wdata_o      <= issue.wdata;
            misaligned_o <= issue.misaligned;
            rd_addr_o    <= issue.rd_addr;
            rd_we_o      <= issue.rd_we;
            commit_id_o  <= issue.commit_id;
        end
    end

    // a stalled packet must not move or change
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (reset_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable({out_unit_o, out_sub_op_o,
            op1_o, op2_o, addr_o, wmask_o, wdata_o, misaligned_o, rd_addr_o, rd_we_o,
            commit_id_o}))
    );

endmodule

`default_nettype wire

/* hw/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top import dispatch_pkg::*; #(
    parameter int COMMIT_DEPTH = 4,
    localparam int ID_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1
) (
    input  wire logic            clk,
    input  wire logic            reset_i,

    // decoded instruction in
    input  wire logic            inst_valid_i,
    output logic                 inst_ready_o,
    input  wire unit_t           unit_i,
    input  wire sub_op_t         sub_op_i,
    input  wire logic            use_imm_i,
    input  wire reg_addr_t       rs1_addr_i,
    input  wire reg_addr_t       rs2_addr_i,
    input  wire reg_addr_t       rd_addr_i,
    input  wire logic            rd_we_i,
    input  wire xlen_t           rs1_rdata_i,
    input  wire xlen_t           rs2_rdata_i,
    input  wire xlen_t           imm_i,
    input  wire xlen_t           pc_i,

    // writeback releases a commit ID
    input  wire logic            commit_valid_i,
    input  wire logic [ID_W-1:0] commit_id_i,

    // towards the functional units
    input  wire logic            out_ready_i,
    output logic                 out_valid_o,
    output unit_t                out_unit_o,
    output sub_op_t              out_sub_op_o,
    output xlen_t                op1_o,
    output xlen_t                op2_o,
    output xlen_t                addr_o,
    output wmask_t               wmask_o,
    output xlen_t                wdata_o,
    output logic                 misaligned_o,
    output reg_addr_t            rd_addr_o,
    output logic                 rd_we_o,
    output logic [ID_W-1:0]      commit_id_o
);

    logic            hdu_accept;
    logic [ID_W-1:0] hdu_alloc_id;

    issue_if #(.COMMIT_DEPTH(COMMIT_DEPTH)) issue ();

    dispatch_hdu #(.COMMIT_DEPTH(COMMIT_DEPTH)) u_dispatch_hdu (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .unit_i        (unit_i),
        .sub_op_i      (sub_op_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rd_addr_i     (rd_addr_i),
        .rd_we_i       (rd_we_i),
        .pipe_ready_i  (issue.ready),
        .commit_valid_i(commit_valid_i),
        .commit_id_i   (commit_id_i),
        .inst_ready_o  (inst_ready_o),
        .accept_o      (hdu_accept),
        .alloc_id_o    (hdu_alloc_id)
    );

    dispatch_logic #(.COMMIT_DEPTH(COMMIT_DEPTH)) u_dispatch_logic (
        .accept_i   (hdu_accept),
        .alloc_id_i (hdu_alloc_id),
        .unit_i     (unit_i),
        .sub_op_i   (sub_op_i),
        .use_imm_i  (use_imm_i),
        .rs1_rdata_i(rs1_rdata_i),
        .rs2_rdata_i(rs2_rdata_i),
        .imm_i      (imm_i),
        .pc_i       (pc_i),
        .rd_addr_i  (rd_addr_i),
        .rd_we_i    (rd_we_i),
        .issue      (issue.producer)
    );

    dispatch_pipe #(.COMMIT_DEPTH(COMMIT_DEPTH)) u_dispatch_pipe (
        .clk         (clk),
        .reset_i     (reset_i),
        .out_ready_i (out_ready_i),
        .issue       (issue.consumer),
        .out_valid_o (out_valid_o),
        .out_unit_o  (out_unit_o),
        .out_sub_op_o(out_sub_op_o),
        .op1_o       (op1_o),
        .op2_o       (op2_o),
        .addr_o      (addr_o),
        .wmask_o     (wmask_o),
        .wdata_o     (wdata_o),
        .misaligned_o(misaligned_o),
        .rd_addr_o   (rd_addr_o),
        .rd_we_o     (rd_we_o),
        .commit_id_o (commit_id_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch import dispatch_pkg::*; ();

    localparam int DEPTH      = 4;
    localparam int ID_W       = 2;
    localparam int N_TXN      = 400;
    localparam int CLK_NS     = 40;
    localparam int MAX_CYCLES = N_TXN * 20 + 16;

    typedef struct packed {
        unit_t           unit;
        sub_op_t         sub_op;
        xlen_t           op1;
        xlen_t           op2;
        xlen_t           addr;
        wmask_t          wmask;
        xlen_t           wdata;
        logic            misaligned;
        reg_addr_t       rd_addr;
        logic            rd_we;
        logic            is_long;
        logic [ID_W-1:0] cid;
    } pkt_t;

    logic            clk;
    logic            reset_i;
    logic            inst_valid;
    logic            inst_ready;
    unit_t           unit;
    sub_op_t         sub_op;
    logic            use_imm;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    reg_addr_t       rd_addr;
    logic            rd_we;
    xlen_t           rs1_rdata;
    xlen_t           rs2_rdata;
    xlen_t           imm;
    xlen_t           pc;
    logic            commit_valid;
    logic [ID_W-1:0] commit_id;
    logic            out_ready;
    logic            out_valid;
    unit_t           out_unit;
    sub_op_t         out_sub_op;
    xlen_t           op1;
    xlen_t           op2;
    xlen_t           addr;
    wmask_t          wmask;
    xlen_t           wdata;
    logic            misaligned;
    reg_addr_t       out_rd_addr;
    logic            out_rd_we;
    logic [ID_W-1:0] out_commit_id;

    // reference model state
    logic [DEPTH-1:0] pend;
    reg_addr_t        sb_rd [DEPTH];
    pkt_t             exp_q [$];
    logic             exp_ready;
    logic             hold;
    logic [31:0]      rng;
    int               errors;
    int               checks;
    int               accepted;

    dispatch_top #(.COMMIT_DEPTH(DEPTH)) dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid),
        .inst_ready_o  (inst_ready),
        .unit_i        (unit),
        .sub_op_i      (sub_op),
        .use_imm_i     (use_imm),
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .rd_addr_i     (rd_addr),
        .rd_we_i       (rd_we),
        .rs1_rdata_i   (rs1_rdata),
        .rs2_rdata_i   (rs2_rdata),
        .imm_i         (imm),
        .pc_i          (pc),
        .commit_valid_i(commit_valid),
        .commit_id_i   (commit_id),
        .out_ready_i   (out_ready),
        .out_valid_o   (out_valid),
        .out_unit_o    (out_unit),
        .out_sub_op_o  (out_sub_op),
        .op1_o         (op1),
        .op2_o         (op2),
        .addr_o        (addr),
        .wmask_o       (wmask),
        .wdata_o       (wdata),
        .misaligned_o  (misaligned),
        .rd_addr_o     (out_rd_addr),
        .rd_we_o       (out_rd_we),
        .commit_id_o   (out_commit_id)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2);
            clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // muldiv, or a load that writes a register
    function automatic logic long_instr();
        logic is_store;
        is_store = mem_op_t'(sub_op) inside {MEM_SB, MEM_SH, MEM_SW};
        return (unit == UNIT_MULDIV) || ((unit == UNIT_MEM) && !is_store && rd_we);
    endfunction

    function automatic logic [ID_W-1:0] lowest_free();
        logic [ID_W-1:0] id;
        logic            found;
        id    = '0;
        found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && !pend[i]) begin
                id    = ID_W'(i);
                found = 1'b1;
            end
        end
        return id;
    endfunction

    // hazard and space rule, from the mirror before the edge
    function automatic logic model_ready();
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (pend[i] && (sb_rd[i] != 5'd0)) begin
                if ((sb_rd[i] == rs1_addr) || (sb_rd[i] == rs2_addr) ||
                    (rd_we && (sb_rd[i] == rd_addr))) begin
                    hit = 1'b1;
                end
            end
        end
        if (long_instr() && (&pend)) begin
            hit = 1'b1;
        end
        return !hit && ((exp_q.size() == 0) || out_ready);
    endfunction

    function automatic pkt_t expected_packet();
        pkt_t  p;
        xlen_t ea;
        p        = '0;
        p.unit   = unit;
        p.sub_op = sub_op;
        p.op1    = rs1_rdata;
        p.op2    = ((unit == UNIT_ALU) && use_imm) ? imm : rs2_rdata;
        if ((unit == UNIT_BJP) && (sub_op != BJP_JALR)) begin
            ea = pc + imm;
        end else begin
            ea = rs1_rdata + imm;
        end
        p.addr = ea;
        if (unit == UNIT_MEM) begin
            case (mem_op_t'(sub_op))
                MEM_LH, MEM_LHU, MEM_SH: p.misaligned = ea[0];
                MEM_LW, MEM_SW:          p.misaligned = (ea[1:0] != 2'b00);
                default:                 p.misaligned = 1'b0;
            endcase
            if (!p.misaligned && (mem_op_t'(sub_op) == MEM_SB)) begin
                p.wmask = 4'b0001 << ea[1:0];
                p.wdata = {4{rs2_rdata[7:0]}};
            end else if (!p.misaligned && (mem_op_t'(sub_op) == MEM_SH)) begin
                p.wmask = ea[1] ? 4'b1100 : 4'b0011;
                p.wdata = {2{rs2_rdata[15:0]}};
            end else if (!p.misaligned && (mem_op_t'(sub_op) == MEM_SW)) begin
                p.wmask = 4'b1111;
                p.wdata = rs2_rdata;
            end
        end
        p.rd_addr = rd_addr;
        p.rd_we   = rd_we;
        p.is_long = long_instr();
        p.cid     = lowest_free();
        return p;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        int          idx;
        r            = next_random();
        commit_valid = 1'b0;
        commit_id    = '0;
        // free a random pending entry now and then
        if (r[2:0] < 3'd3) begin
            for (int k = 0; k < DEPTH; k++) begin
                idx = (int'(r[4:3]) + k) % DEPTH;
                if (!commit_valid && pend[idx]) begin
                    commit_valid = 1'b1;
                    commit_id    = ID_W'(idx);
                end
            end
        end
        out_ready = (r[9:8] != 2'b00);
        if (accepted >= N_TXN) begin
            inst_valid = 1'b0;
        end else if (!hold) begin
            r          = next_random();
            inst_valid = (r[1:0] != 2'b00);
            unit       = unit_t'(r[3:2]);
            sub_op     = sub_op_t'(r[6:4]);
            use_imm    = r[7];
            // small register range so that hazards are common
            rs1_addr   = 5'(r[10:8]);
            rs2_addr   = 5'(r[13:11]);
            rd_addr    = 5'(r[16:14]);
            rd_we      = (r[18:17] != 2'b00);
            imm        = {{20{r[31]}}, r[31:20]};
            rs1_rdata  = next_random();
            rs2_rdata  = next_random();
            pc         = next_random() & 32'hffff_fffc;
        end
    endtask

    // a stalled packet is compared with the same queue head every cycle
    task automatic check_outputs();
        pkt_t p;
        exp_ready = model_ready();
        compare_value(32'(inst_ready), 32'(exp_ready), "inst_ready_o");
        compare_value(32'(out_valid), 32'(exp_q.size() != 0), "out_valid_o");
        if ((exp_q.size() != 0) && out_valid) begin
            p = exp_q[0];
            compare_value(32'(out_unit), 32'(p.unit), "out_unit_o");
            compare_value(32'(out_sub_op), 32'(p.sub_op), "out_sub_op_o");
            compare_value(op1, p.op1, "op1_o");
            compare_value(32'(misaligned), 32'(p.misaligned), "misaligned_o");
            compare_value(32'(out_rd_addr), 32'(p.rd_addr), "rd_addr_o");
            compare_value(32'(out_rd_we), 32'(p.rd_we), "rd_we_o");
            if (p.unit != UNIT_MEM) begin
                compare_value(op2, p.op2, "op2_o");
            end
            if ((p.unit == UNIT_BJP) || (p.unit == UNIT_MEM)) begin
                compare_value(addr, p.addr, "addr_o");
            end
            if (p.unit == UNIT_MEM) begin
                compare_value(32'(wmask), 32'(p.wmask), "wmask_o");
            end
            if (p.wmask != 4'b0000) begin
                compare_value(wdata, p.wdata, "wdata_o");
            end
            if (p.is_long) begin
                compare_value(32'(out_commit_id), 32'(p.cid), "commit_id_o");
            end
        end
    endtask

    // what the coming edge does to the mirror
    task automatic update_model();
        logic take;
        pkt_t p;
        take = inst_valid && exp_ready;
        p    = expected_packet();
        if ((exp_q.size() != 0) && out_ready) begin
            exp_q.delete(0);
        end
        if (commit_valid) begin
            pend[commit_id] = 1'b0;
        end
        if (take) begin
            if (p.is_long) begin
                pend[p.cid]  = 1'b1;
                sb_rd[p.cid] = rd_we ? rd_addr : 5'd0;
            end
            exp_q.push_back(p);
            accepted++;
        end
        hold = inst_valid && !take;
    endtask

    initial begin
        #(MAX_CYCLES * CLK_NS);
        $display("timeout: %0d of %0d instructions after %0d cycles", accepted, N_TXN,
                 MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        inst_valid   = 1'b0;
        unit         = UNIT_ALU;
        sub_op       = '0;
        use_imm      = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        rd_addr      = '0;
        rd_we        = 1'b0;
        rs1_rdata    = '0;
        rs2_rdata    = '0;
        imm          = '0;
        pc           = '0;
        commit_valid = 1'b0;
        commit_id    = '0;
        out_ready    = 1'b0;
        pend         = '0;
        hold         = 1'b0;
        rng          = 32'hf944;
        errors       = 0;
        checks       = 0;
        accepted     = 0;
        for (int i = 0; i < DEPTH; i++) begin
            sb_rd[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;
        while ((accepted < N_TXN) || (exp_q.size() != 0)) begin
            drive_inputs();
            #20;
            check_outputs();
            update_model();
            @(posedge clk);
            #2;
        end
        $display("instructions: %0d, checks: %0d, errors: %0d", accepted, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/dispatch_pkg.sv
hw/issue_if.sv
hw/dispatch_hdu.sv
hw/dispatch_logic.sv
hw/dispatch_pipe.sv
hw/dispatch_top.sv
testbench/tb_dispatch.sv

/* run.sh */
#!/bin/sh
# build the dispatch testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 --top-module tb_dispatch -f flist.f \
    && ./obj_dir/Vtb_dispatch | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
